/* Bender.yml */
package:
  name: microCalculator

sources:
  - files:
      - verilog/microCalcPkg.sv
      - verilog/controlStore.sv
      - verilog/microSequencer.sv
      - verilog/aluUnit.sv
      - verilog/workRegisters.sv
      - verilog/microCalculator.sv

  - target: simulation
    files:
      - sim/microCalculatorTb.sv

/* all.f */
verilog/microCalcPkg.sv
verilog/controlStore.sv
verilog/microSequencer.sv
verilog/aluUnit.sv
verilog/workRegisters.sv
verilog/microCalculator.sv
sim/microCalculatorTb.sv

/* sim/microCalculatorTb.sv */
// Testbench for the microprogrammed 8-bit calculator
// Table rows plus xorshift rows, checked against a reference model

module microCalculatorTb;

        typedef struct packed {
                microCalcPkg::opcodeT op;
                microCalcPkg::dataT   a;
                microCalcPkg::dataT   b;
                microCalcPkg::dataT   expected;               // Ignored for unused opcodes
        } rowT;

        logic                 clk;
        logic                 reset;
        logic                 go;
        microCalcPkg::opcodeT opcode;
        microCalcPkg::dataT   dataA;
        microCalcPkg::dataT   dataB;
        microCalcPkg::dataT   result;

        rowT         rows [0:23];                               // 12 fixed, 12 random
        logic [31:0] rngState;
        int          errors;
        int          checks;
        int          cycleCount;
        int          cycleLimit;

        microCalculator microCalculator_i (
                .clk(clk), .reset(reset), .go(go), .opcode(opcode),
                .dataA(dataA), .dataB(dataB), .result(result)
        );

        initial begin
                clk = 1'b0;
                forever #20 clk = ~clk;                         // Period 40
        end

        // ------------------------------------------------------------------
        // Reference model and helpers
        // ------------------------------------------------------------------
        function automatic logic [31:0] nextRandom(input logic [31:0] x);
                logic [31:0] y;
                y = x;
                y = y ^ (y << 13);
                y = y ^ (y >> 17);
                y = y ^ (y << 5);
                return y;
        endfunction

        function automatic logic isOperation(input microCalcPkg::opcodeT op);
                return (op == 4'd3) || (op == 4'd7) || (op == 4'd12);
        endfunction

        function automatic microCalcPkg::dataT expectedResult(input microCalcPkg::opcodeT op,
                        input microCalcPkg::dataT a, input microCalcPkg::dataT b);
                logic [15:0] product;
                product = a * b;
                case (op)
                4'd3:    return a + b;                          // Wraps at 8 bits
                4'd7:    return a - b;
                4'd12:   return product[7:0];
                default: return 8'hFF;
                endcase
        endfunction

        task automatic checkValue(input microCalcPkg::dataT expected, input string what);
                checks++;
                assert (result === expected) else begin
                        errors++;
                        $display("[FAIL] %0t: %s, result %h expected %h",
                                 $time, what, result, expected);
                end
        endtask

        // Unused opcodes cycle through power-up, so only flash values show
        task automatic checkFlashOnly(input microCalcPkg::opcodeT op);
                checks++;
                assert (result === 8'hFF || result === 8'h00) else begin
                        errors++;
                        $display("[FAIL] %0t: unused opcode %0d shows result %h",
                                 $time, op, result);
                end
        endtask

        task automatic runRow(input rowT row);
                int   holdCycles;
                logic known;
                holdCycles = 2 * row.b + 12;
                known      = isOperation(row.op);
                @(negedge clk);
                opcode = row.op;
                dataA  = row.a;
                dataB  = row.b;
                @(negedge clk);
                go = 1'b1;
                repeat (holdCycles) begin
                        @(negedge clk);
                        if (!known) checkFlashOnly(row.op);
                end
                if (known) checkValue(row.expected, "result at end of hold");
                go = 1'b0;                                      // Release on this falling edge
                if (known) begin
                        @(negedge clk);
                        checkValue(row.expected, "result one edge after release");
                        @(negedge clk);
                        checkValue(8'h00, "flash 00 two edges after release");
                        @(negedge clk);
                        checkValue(8'hFF, "idle after return");
                end else begin
                        repeat (8) @(negedge clk);              // Power-up loop is 6 steps
                        checkValue(8'hFF, "idle after unused opcode");
                end
        endtask

        // ------------------------------------------------------------------
        // Timeout
        // ------------------------------------------------------------------
        always @(posedge clk) begin
                cycleCount++;
                if (cycleCount > cycleLimit) begin
                        $display("Timeout: run passed the limit of %0d cycles", cycleLimit);
                        $display("Checks: %0d, errors: %0d, timeouts: 1", checks, errors);
                        $display("TEST FAIL");
                        $finish;
                end
        end

        // ------------------------------------------------------------------
        // Stimulus
        // ------------------------------------------------------------------
        initial begin
                int i;
                errors     = 0;
                checks     = 0;
                cycleCount = 0;
                reset      = 1'b1;
                go         = 1'b0;
                opcode     = '0;
                dataA      = '0;
                dataB      = '0;

                // Opcode, A, B, expected
                rows[0]  = {4'd3,  8'h12, 8'h30, 8'h42};
                rows[1]  = {4'd3,  8'hC8, 8'h64, 8'h2C};        // Carry out
                rows[2]  = {4'd3,  8'hFF, 8'h01, 8'h00};
                rows[3]  = {4'd7,  8'h50, 8'h20, 8'h30};
                rows[4]  = {4'd7,  8'h10, 8'h20, 8'hF0};        // Borrow
                rows[5]  = {4'd7,  8'h00, 8'h00, 8'h00};
                rows[6]  = {4'd12, 8'h07, 8'h06, 8'h2A};
                rows[7]  = {4'd12, 8'h25, 8'h00, 8'h00};        // B of 0 skips the loop
                rows[8]  = {4'd12, 8'h5B, 8'h01, 8'h5B};
                rows[9]  = {4'd12, 8'hFF, 8'h0F, 8'hF1};        // Wraps
                rows[10] = {4'd14, 8'h12, 8'h34, 8'hFF};        // Old divide slot
                rows[11] = {4'd0,  8'h55, 8'h03, 8'hFF};

                rngState = 32'd4;
                for (i = 12; i < $size(rows); i++) begin
                        rngState = nextRandom(rngState);
                        case (rngState[1:0])
                        2'd0:    rows[i].op = 4'd3;
                        2'd1:    rows[i].op = 4'd7;
                        default: rows[i].op = 4'd12;
                        endcase
                        rows[i].a        = rngState[15:8];
                        rows[i].b        = {4'h0, rngState[19:16]};     // Keeps multiply short
                        rows[i].expected = expectedResult(rows[i].op, rows[i].a, rows[i].b);
                end

                cycleLimit = 40;                                // Reset and idle check
                for (i = 0; i < $size(rows); i++) begin
                        cycleLimit += 2 * rows[i].b + 12 + 12;
                end
                cycleLimit += 50;

                repeat (3) @(negedge clk);
                reset = 1'b0;
                repeat (4) @(negedge clk);                      // FF, temps, 00, FF
                repeat (6) begin
                        checkValue(8'hFF, "idle after reset");
                        @(negedge clk);
                end

                for (i = 0; i < $size(rows); i++) begin
                        runRow(rows[i]);
                end

                $display("Checks: %0d, errors: %0d, timeouts: 0", checks, errors);
                if (errors == 0) begin
                        $display("TEST PASS");
                end else begin
                        $display("TEST FAIL");
                end
                $finish;
        end

endmodule

/* verilog/microCalculator.sv */
// Top level of the microprogrammed 8-bit calculator
// Sequencer, control store, ALU and registers

module microCalculator (
        input  logic                 clk,
        input  logic                 reset,
        input  logic                 go,
        input  microCalcPkg::opcodeT opcode,
        input  microCalcPkg::dataT   dataA,
        input  microCalcPkg::dataT   dataB,
        output microCalcPkg::dataT   result
);

        microCalcPkg::microAddrT microAddress;
        microCalcPkg::microAddrT nextAddress;
        microCalcPkg::branchOpE  branchOp;
        microCalcPkg::aluFuncE   aluFunc;
        microCalcPkg::aluDestE   aluDest;
        microCalcPkg::dataT      operandA;
        microCalcPkg::dataT      operandB;
        microCalcPkg::dataT      tempA;
        microCalcPkg::dataT      tempB;
        microCalcPkg::dataT      aluOut;
        logic                    carryIn;
        logic                    aSource;
        logic                    bSource;
        logic                    resultZero;
        logic                    loadInputs;

        microSequencer microSequencer_i (
                .clk(clk), .reset(reset), .go(go), .opcode(opcode),
                .nextAddress(nextAddress), .branchOp(branchOp), .resultZero(resultZero),
                .microAddress(microAddress), .loadInputs(loadInputs)
        );

        controlStore controlStore_i (
                .microAddress(microAddress), .nextAddress(nextAddress), .branchOp(branchOp),
                .aluFunc(aluFunc), .carryIn(carryIn), .aSource(aSource), .bSource(bSource),
                .aluDest(aluDest)
        );

        aluUnit aluUnit_i (
                .operandA(operandA), .operandB(operandB), .tempA(tempA), .tempB(tempB),
                .aSource(aSource), .bSource(bSource), .carryIn(carryIn),
                .aluFunc(aluFunc), .aluOut(aluOut)
        );

        workRegisters workRegisters_i (
                .clk(clk), .reset(reset), .loadInputs(loadInputs),
                .dataA(dataA), .dataB(dataB), .aluOut(aluOut), .aluDest(aluDest),
                .operandA(operandA), .operandB(operandB), .tempA(tempA), .tempB(tempB),
                .result(result), .resultZero(resultZero)
        );

endmodule

/* verilog/workRegisters.sv */
// Register file of the calculator
// Input operands, two temporaries and the F result register

module workRegisters (
        input  logic                  clk,
        input  logic                  reset,
        input  logic                  loadInputs,
        input  microCalcPkg::dataT    dataA,
        input  microCalcPkg::dataT    dataB,
        input  microCalcPkg::dataT    aluOut,
        input  microCalcPkg::aluDestE aluDest,
        output microCalcPkg::dataT    operandA,
        output microCalcPkg::dataT    operandB,
        output microCalcPkg::dataT    tempA,
        output microCalcPkg::dataT    tempB,
        output microCalcPkg::dataT    result,
        output logic                  resultZero
);

        logic writeF;
        logic writeTempA;
        logic writeTempB;

        assign writeF     = (aluDest == microCalcPkg::toF) ||
                            (aluDest == microCalcPkg::toFAndTempA);
        assign writeTempA = (aluDest == microCalcPkg::toTempA) ||
                            (aluDest == microCalcPkg::toTempBoth) ||
                            (aluDest == microCalcPkg::toFAndTempA);
        assign writeTempB = (aluDest == microCalcPkg::toTempB) ||
                            (aluDest == microCalcPkg::toTempBoth);

        always_ff @(posedge clk) begin
                if (reset) begin
                        operandA <= '0;
                        operandB <= '0;
                        tempA    <= '0;
                        tempB    <= '0;
                        result   <= '0;
                end else begin
                        if (loadInputs) begin           // Dispatch edge
                                operandA <= dataA;
                                operandB <= dataB;
                        end
                        if (writeF)     result <= aluOut;
                        if (writeTempA) tempA  <= aluOut;
                        if (writeTempB) tempB  <= aluOut;
                end
        end

        assign resultZero = (result == 8'h00);          // Branch test uses the stored F

        // Wait steps with no destination keep the result on display
        assert property (@(posedge clk) disable iff (reset)
                aluDest == microCalcPkg::toNone |=> $stable(result));

endmodule

/* verilog/aluUnit.sv */
// ALU of the calculator
// Picks input or temp operands and applies the microword function

module aluUnit (
        input  microCalcPkg::dataT    operandA,
        input  microCalcPkg::dataT    operandB,
        input  microCalcPkg::dataT    tempA,
        input  microCalcPkg::dataT    tempB,
        input  logic                  aSource,
        input  logic                  bSource,
        input  logic                  carryIn,
        input  microCalcPkg::aluFuncE aluFunc,
        output microCalcPkg::dataT    aluOut
);

        microCalcPkg::dataT aSide;
        microCalcPkg::dataT bSide;

        assign aSide = aSource ? operandA : tempA;      // 1 selects the input register
        assign bSide = bSource ? operandB : tempB;

        // All results wrap modulo 256
        always_comb begin
                case (aluFunc)
                microCalcPkg::allOnes:   aluOut = 8'hFF;
                microCalcPkg::allZeros:  aluOut = 8'h00;
                microCalcPkg::passB:     aluOut = bSide;
                microCalcPkg::aPlusB:    aluOut = aSide + bSide + {7'd0, carryIn};
                microCalcPkg::aMinusB:   aluOut = aSide + ~bSide + {7'd0, carryIn};
                microCalcPkg::aMinusOne: aluOut = aSide - 8'd1;
                default:                 aluOut = 8'hFF;
                endcase
        end

endmodule

/* verilog/microSequencer.sv */
// Microaddress counter of the calculator
// Counts, branches, waits on go and dispatches on the opcode

module microSequencer (
        input  logic                    clk,
        input  logic                    reset,
        input  logic                    go,
        input  microCalcPkg::opcodeT    opcode,
        input  microCalcPkg::microAddrT nextAddress,
        input  microCalcPkg::branchOpE  branchOp,
        input  logic                    resultZero,         // Registered F is zero
        output microCalcPkg::microAddrT microAddress,
        output logic                    loadInputs
);

        microCalcPkg::microAddrT addrPlusOne;
        microCalcPkg::microAddrT addrNext;

        assign addrPlusOne = microAddress + 8'd1;
        assign loadInputs  = !reset && (branchOp == microCalcPkg::dispatch);   // Dispatch step

        always_comb begin
                case (branchOp)
                microCalcPkg::count:       addrNext = addrPlusOne;
                microCalcPkg::branch:      addrNext = nextAddress;
                microCalcPkg::waitGo:      addrNext = go ? addrPlusOne : nextAddress;
                microCalcPkg::waitRelease: addrNext = go ? nextAddress : addrPlusOne;
                microCalcPkg::dispatch:    addrNext = {opcode, microCalcPkg::dispatchStep};
                microCalcPkg::loopNonZero: addrNext = resultZero ? addrPlusOne : nextAddress;
                microCalcPkg::jumpIfZero:  addrNext = resultZero ? nextAddress : addrPlusOne;
                default:                   addrNext = microCalcPkg::resetAddr;
                endcase
        end

        // Page nibble doubles as the opcode register after dispatch
        always_ff @(posedge clk) begin
                if (reset) begin
                        microAddress <= microCalcPkg::resetAddr;
                end else begin
                        microAddress <= addrNext;
                end
        end

        // Dispatch step is entered only from idle
        assert property (@(posedge clk) disable iff (reset)
                loadInputs |-> $past(microAddress) == microCalcPkg::idleAddr);

endmodule

/* verilog/controlStore.sv */
// Microprogram table for the calculator
// Maps a microaddress to its microword and splits out the fields

module controlStore (
        input  microCalcPkg::microAddrT microAddress,
        output microCalcPkg::microAddrT nextAddress,
        output microCalcPkg::branchOpE  branchOp,
        output microCalcPkg::aluFuncE   aluFunc,
        output logic                    carryIn,
        output logic                    aSource,            // 1 input A, 0 temp A
        output logic                    bSource,            // 1 input B, 0 temp B
        output microCalcPkg::aluDestE   aluDest
);

        microCalcPkg::microWordT word;

        // Packs the fields at their fixed bit positions
        function automatic microCalcPkg::microWordT mw(
                input microCalcPkg::aluDestE   dest,
                input logic                    cin,
                input microCalcPkg::aluFuncE   func,
                input logic                    bSrc,
                input logic                    aSrc,
                input microCalcPkg::branchOpE  bop,
                input microCalcPkg::microAddrT next);
                mw = {dest, cin, func, bSrc, aSrc, bop, 1'b0, next};
        endfunction

        always_comb begin
                case (microAddress)
                // ----------------------------------------------------------------
                // Power-up and idle
                // ----------------------------------------------------------------
                8'h00: word = mw(microCalcPkg::toF, 1'b0, microCalcPkg::allOnes, 1'b1, 1'b1,
                                 microCalcPkg::branch, 8'h0B);              // Flash FF
                8'h0B: word = mw(microCalcPkg::toTempBoth, 1'b0, microCalcPkg::allOnes, 1'b1,
                                 1'b1, microCalcPkg::count, 8'h00);         // Temps to known value
                8'h0C: word = mw(microCalcPkg::toF, 1'b0, microCalcPkg::allZeros, 1'b1, 1'b1,
                                 microCalcPkg::count, 8'h00);               // Flash 00
                8'h0D: word = mw(microCalcPkg::toF, 1'b0, microCalcPkg::allOnes, 1'b1, 1'b1,
                                 microCalcPkg::waitGo, microCalcPkg::idleAddr);
                8'h0E: word = mw(microCalcPkg::toF, 1'b0, microCalcPkg::allOnes, 1'b1, 1'b1,
                                 microCalcPkg::dispatch,
                                 {4'hF, microCalcPkg::dispatchStep});       // Page from opcode
                // ----------------------------------------------------------------
                // Opcode 3, add
                // ----------------------------------------------------------------
                8'h31: word = mw(microCalcPkg::toF, 1'b0, microCalcPkg::aPlusB, 1'b1, 1'b1,
                                 microCalcPkg::count, 8'h00);               // A + B into F
                8'h32: word = mw(microCalcPkg::toNone, 1'b0, microCalcPkg::allOnes, 1'b1, 1'b1,
                                 microCalcPkg::waitRelease, 8'h32);
                8'h33: word = mw(microCalcPkg::toF, 1'b0, microCalcPkg::allZeros, 1'b1, 1'b1,
                                 microCalcPkg::branch, microCalcPkg::idleAddr);
                // ----------------------------------------------------------------
                // Opcode 7, subtract
                // ----------------------------------------------------------------
                8'h71: word = mw(microCalcPkg::toF, 1'b1, microCalcPkg::aMinusB, 1'b1, 1'b1,
                                 microCalcPkg::count, 8'h00);               // A + ~B + 1
                8'h72: word = mw(microCalcPkg::toNone, 1'b0, microCalcPkg::allOnes, 1'b1, 1'b1,
                                 microCalcPkg::waitRelease, 8'h72);
                8'h73: word = mw(microCalcPkg::toF, 1'b0, microCalcPkg::allZeros, 1'b1, 1'b1,
                                 microCalcPkg::branch, microCalcPkg::idleAddr);
                // ----------------------------------------------------------------
                // Opcode 12, multiply. Temp A counts B down, temp B sums A
                // ----------------------------------------------------------------
                8'hC1: word = mw(microCalcPkg::toTempB, 1'b0, microCalcPkg::allZeros, 1'b0,
                                 1'b1, microCalcPkg::count, 8'h00);         // Clear sum
                8'hC2: word = mw(microCalcPkg::toF, 1'b0, microCalcPkg::passB, 1'b1, 1'b1,
                                 microCalcPkg::count, 8'h00);               // F = B for zero test
                8'hC3: word = mw(microCalcPkg::toTempA, 1'b0, microCalcPkg::passB, 1'b1, 1'b1,
                                 microCalcPkg::jumpIfZero, 8'hC7);          // B of 0 is done
                8'hC4: word = mw(microCalcPkg::toFAndTempA, 1'b0, microCalcPkg::aMinusOne,
                                 1'b0, 1'b0, microCalcPkg::count, 8'h00);   // Count one less
                8'hC5: word = mw(microCalcPkg::toTempB, 1'b0, microCalcPkg::aPlusB, 1'b0, 1'b1,
                                 microCalcPkg::count, 8'h00);               // Sum += A
                8'hC6: word = mw(microCalcPkg::toFAndTempA, 1'b0, microCalcPkg::aMinusOne,
                                 1'b0, 1'b0, microCalcPkg::loopNonZero, 8'hC5);
                8'hC7: word = mw(microCalcPkg::toF, 1'b0, microCalcPkg::passB, 1'b0, 1'b0,
                                 microCalcPkg::waitRelease, 8'hC7);         // Show sum
                8'hC8: word = mw(microCalcPkg::toF, 1'b0, microCalcPkg::allZeros, 1'b1, 1'b1,
                                 microCalcPkg::branch, microCalcPkg::idleAddr);
                // Unused addresses and opcodes restart the power-up sequence
                default: word = mw(microCalcPkg::toF, 1'b0, microCalcPkg::allOnes, 1'b1, 1'b1,
                                   microCalcPkg::branch, microCalcPkg::resetAddr);
                endcase
        end

        assign nextAddress = word[7:0];
        assign branchOp    = microCalcPkg::branchOpE'(word[12:9]);
        assign aSource     = word[13];
        assign bSource     = word[14];
        assign aluFunc     = microCalcPkg::aluFuncE'(word[19:15]);
        assign carryIn     = word[20];
        assign aluDest     = microCalcPkg::aluDestE'(word[23:21]);

        // Table holds only known branch encodings
        always_comb begin
                assert final (branchOp inside {microCalcPkg::count, microCalcPkg::branch,
                        microCalcPkg::waitGo, microCalcPkg::waitRelease, microCalcPkg::dispatch,
                        microCalcPkg::loopNonZero, microCalcPkg::jumpIfZero});
        end

endmodule

/* verilog/microCalcPkg.sv */
// Shared definitions for the microprogrammed 8-bit calculator
// Widths, microword field encodings and fixed microaddresses

package microCalcPkg;

        typedef logic [7:0]  dataT;                     // Operand, temp and result word
        typedef logic [3:0]  opcodeT;                   // Operation code, also the page
        typedef logic [7:0]  microAddrT;                // Page in [7:4], step in [3:0]
        typedef logic [23:0] microWordT;                // Stored microword, bit 8 unused

        // ------------------------------------------------------------------
        // Microword field encodings
        // ------------------------------------------------------------------
        typedef enum logic [3:0] {
                count       = 4'b0110,                  // Step to next microaddress
                branch      = 4'b1110,                  // Unconditional jump
                waitGo      = 4'b0100,                  // Hold while go low
                waitRelease = 4'b1100,                  // Hold while go high
                dispatch    = 4'b1111,                  // Jump to opcode page, load inputs
                loopNonZero = 4'b0101,                  // Jump while F nonzero
                jumpIfZero  = 4'b1101                   // Jump when F zero
        } branchOpE;

        typedef enum logic [4:0] {
                allOnes   = 5'b11100,
                allZeros  = 5'b10011,
                passB     = 5'b11010,
                aPlusB    = 5'b01001,
                aMinusB   = 5'b00110,                   // Needs carry in set
                aMinusOne = 5'b01111
        } aluFuncE;

        typedef enum logic [2:0] {
                toF         = 3'b011,
                toTempBoth  = 3'b100,
                toTempB     = 3'b101,
                toTempA     = 3'b110,
                toFAndTempA = 3'b010,
                toNone      = 3'b111
        } aluDestE;

        // Fixed points of the microprogram
        localparam microAddrT   resetAddr    = 8'h00;   // Power-up sequence start
        localparam microAddrT   idleAddr     = 8'h0D;   // Wait for go
        localparam logic [3:0]  dispatchStep = 4'h1;    // First step of every opcode page

endpackage
